/* Bender.yml */
package:
  name: fpu_lane

dependencies: {}

sources:
  - fpu_data_pkg.sv
  - fpu_op_pkg.sv
  - operand_forward.sv
  - fpu_op_decode.sv
  - fpu_exec.sv
  - fpu_retire.sv
  - fpu_lane.sv
  - target: test
    files:
      - tb_fpu_lane.sv

/* fpu_data_pkg.sv */
/* operand and bus widths, operand, bus word and bus select types,
   parity bit position */
package fpu_data_pkg;

  // one operand holds two single-precision slots
  localparam int DATA_W = 68;
  localparam int HALF_W = 34;

  // bus word is the data with the parity bit on top
  localparam int BUS_W = DATA_W + 1;

  // bit 68 is the xor of bits 67..0, so a good word xors to zero
  localparam int PAR_BIT = DATA_W;

  // result buses seen by the forwarders
  localparam int NUM_BUS = 4;

  // operand or result value without parity
  typedef logic [DATA_W-1:0] fp_data_t;

  // parity-protected word as carried on a result bus
  typedef logic [BUS_W-1:0] bus_word_t;

  // one-hot bus select, zero means no bus
  typedef logic [NUM_BUS-1:0] bus_sel_t;

endpackage

/* fpu_exec.sv */
/* logic and half-word permute datapath, class select and registered
   raw flags */
`timescale 1ns/1ns

module fpu_exec
  import fpu_data_pkg::*;
  import fpu_op_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 valid_in,
  input  op_class_e            op_class,
  input  logic_fn_e            logic_fn,
  input  perm_fn_e             perm_fn,
  input  fp_data_t             a,
  input  fp_data_t             b,
  input  logic                 par_err_a,
  input  logic                 par_err_b,
  output logic                 valid,
  output fp_data_t             data,
  output logic [NUM_FLAGS-1:0] flags
);

  fp_data_t logic_res;
  fp_data_t perm_res;
  fp_data_t data_d;
  logic [NUM_FLAGS-1:0] flags_d;

  always_comb begin
    case (logic_fn)
      FN_AND:  logic_res = a & b;
      FN_OR:   logic_res = a | b;
      FN_XOR:  logic_res = a ^ b;
      default: logic_res = a & ~b;
    endcase
  end

  // halves are the two single-precision slots
  always_comb begin
    case (perm_fn)
      PERM_COPYA: perm_res = a;
      PERM_SWAP:  perm_res = {a[HALF_W-1:0], a[DATA_W-1:HALF_W]};
      PERM_DUP:   perm_res = {b[HALF_W-1:0], b[HALF_W-1:0]};
      default:    perm_res = {a[DATA_W-1:HALF_W], b[HALF_W-1:0]};
    endcase
  end

  always_comb begin
    case (op_class)
      CLS_LOGIC: data_d = logic_res;
      CLS_PERM:  data_d = perm_res;
      default:   data_d = '0;
    endcase
  end

  always_comb begin
    flags_d             = '0;
    flags_d[RET_PAR_A]  = par_err_a;
    flags_d[RET_PAR_B]  = par_err_b;
    flags_d[RET_BAD_OP] = (op_class == CLS_BAD);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    data  <= data_d;
    flags <= flags_d;
  end

endmodule

/* fpu_lane.f */
fpu_data_pkg.sv
fpu_op_pkg.sv
operand_forward.sv
fpu_op_decode.sv
fpu_exec.sv
fpu_retire.sv
fpu_lane.sv
tb_fpu_lane.sv

/* fpu_lane.sv */
/* execution lane top with operand forwarders, decoder, datapath
   and retire stage */
`timescale 1ns/1ns

module fpu_lane
  import fpu_data_pkg::*;
  import fpu_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  op_t       op,
  input  bus_word_t a,
  input  bus_word_t b,
  input  bus_word_t fwd_bus [NUM_BUS],
  input  bus_sel_t  fwd_sel_a,
  input  bus_sel_t  prev_sel_a,
  input  bus_sel_t  fwd_sel_b,
  input  bus_sel_t  prev_sel_b,
  input  csr_en_t   csr_en,
  output logic      result_valid,
  output bus_word_t result,
  output logic      ret_valid,
  output ret_code_t ret_code
);

  // stage 1
  fp_data_t  opnd_a;
  fp_data_t  opnd_b;
  logic      par_err_a;
  logic      par_err_b;
  logic      dec_valid;
  op_class_e dec_class;
  logic_fn_e dec_logic_fn;
  perm_fn_e  dec_perm_fn;

  // stage 2
  logic                 ex_valid;
  fp_data_t             ex_data;
  logic [NUM_FLAGS-1:0] ex_flags;

  operand_forward fwd_a (
    .clk      (clk),
    .rst      (rst),
    .direct   (a),
    .fwd_bus  (fwd_bus),
    .fwd_sel  (fwd_sel_a),
    .prev_sel (prev_sel_a),
    .operand  (opnd_a),
    .par_err  (par_err_a)
  );

  operand_forward fwd_b (
    .clk      (clk),
    .rst      (rst),
    .direct   (b),
    .fwd_bus  (fwd_bus),
    .fwd_sel  (fwd_sel_b),
    .prev_sel (prev_sel_b),
    .operand  (opnd_b),
    .par_err  (par_err_b)
  );

  fpu_op_decode dec0 (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .op       (op),
    .valid    (dec_valid),
    .op_class (dec_class),
    .logic_fn (dec_logic_fn),
    .perm_fn  (dec_perm_fn)
  );

  fpu_exec exec0 (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (dec_valid),
    .op_class  (dec_class),
    .logic_fn  (dec_logic_fn),
    .perm_fn   (dec_perm_fn),
    .a         (opnd_a),
    .b         (opnd_b),
    .par_err_a (par_err_a),
    .par_err_b (par_err_b),
    .valid     (ex_valid),
    .data      (ex_data),
    .flags     (ex_flags)
  );

  fpu_retire ret0 (
    .clk          (clk),
    .rst          (rst),
    .valid_in     (ex_valid),
    .data         (ex_data),
    .flags        (ex_flags),
    .csr_en       (csr_en),
    .result_valid (result_valid),
    .result       (result),
    .ret_valid    (ret_valid),
    .ret_code     (ret_code)
  );

endmodule

/* fpu_lane_input.hex */
// test en op fwd_sel_a prev_sel_a fwd_sel_b prev_sel_b a b csr_en corrupt
// a and b are 68-bit data, parity added on load; corrupt bit 0 flips a, bit 1 flips b
01 0 00 0 0 0 0 00000000000000000 00000000000000000 7 0
01 0 00 0 0 0 0 00000000000000000 00000000000000000 7 0
02 1 20 0 0 0 0 F0F0F0F0F0F0F0F0F 0FF00FF00FF00FF00 7 0
02 1 21 0 0 0 0 123456789ABCDEF01 FEDCBA9876543210F 7 0
02 1 22 0 0 0 0 A5A5A5A5A5A5A5A5A 5A5A5A5A5A5A5A5A0 7 0
02 1 23 0 0 0 0 FFFFFFFFFFFFFFFFF 0F0F0F0F0F0F0F0F0 7 0
03 1 30 0 0 0 0 3C3C3C3C3C3C3C3C3 00000000000000000 7 0
03 1 31 0 0 0 0 0123456789ABCDEF1 00000000000000000 7 0
03 1 32 0 0 0 0 00000000000000000 9876543210ABCDEF1 7 0
03 1 33 0 0 0 0 AAAAAAAAAAAAAAAAA 55555555555555555 7 0
04 1 22 1 0 0 0 00000000000000000 0000000000000FFFF 7 0
04 1 22 0 4 8 0 00000000000000000 00000000000000000 7 0
04 1 22 0 0 0 2 13579BDF02468ACE1 00000000000000000 7 0
04 1 22 0 8 0 1 00000000000000000 00000000000000000 7 0
05 1 20 0 0 0 0 0DEADBEEF0CAFEF00 FFFFFFFFFFFFFFFFF 7 1
05 1 21 0 0 0 0 0DEADBEEF0CAFEF00 00000000000000001 7 2
05 1 55 0 0 0 0 0DEADBEEF0CAFEF00 00000000000000001 7 0
05 0 00 0 0 0 0 00000000000000000 00000000000000000 7 0
05 0 00 0 0 0 0 00000000000000000 00000000000000000 7 0
05 1 20 0 0 0 0 0DEADBEEF0CAFEF00 FFFFFFFFFFFFFFFFF 0 1
05 1 21 0 0 0 0 0DEADBEEF0CAFEF00 00000000000000001 0 2
05 1 55 0 0 0 0 0DEADBEEF0CAFEF00 00000000000000001 0 0
06 1 31 0 0 0 0 0000000011111111F 00000000000000000 0 0
06 1 23 2 0 0 0 00000000000000000 00000000000000FFF 0 0
06 1 33 0 0 1 0 76543210FEDCBA987 00000000000000000 0 0

/* fpu_op_decode.sv */
/* opcode decode into operation class and function, registered with
   the enable strobe */
`timescale 1ns/1ns

module fpu_op_decode
  import fpu_data_pkg::*;
  import fpu_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  op_t       op,
  output logic      valid,
  output op_class_e op_class,
  output logic_fn_e logic_fn,
  output perm_fn_e  perm_fn
);

  op_class_e cls_d;
  logic_fn_e lfn_d;
  perm_fn_e  pfn_d;

  always_comb begin
    cls_d = CLS_BAD;
    lfn_d = logic_fn_e'(op[1:0]);
    pfn_d = PERM_COPYA;
    if ({op[7:2], 2'b00} == OP_LOGIC) begin
      cls_d = CLS_LOGIC;
    end else begin
      case (op)
        OP_PERM_COPYA: begin
          cls_d = CLS_PERM;
          pfn_d = PERM_COPYA;
        end
        OP_PERM_SWAP: begin
          cls_d = CLS_PERM;
          pfn_d = PERM_SWAP;
        end
        OP_PERM_DUP: begin
          cls_d = CLS_PERM;
          pfn_d = PERM_DUP;
        end
        OP_PERM_MERGE: begin
          cls_d = CLS_PERM;
          pfn_d = PERM_MERGE;
        end
        default: cls_d = CLS_BAD;
      endcase
    end
  end

  // fields only load with en so they stay known between operations
  always_ff @(posedge clk) begin
    if (rst) begin
      valid    <= 1'b0;
      op_class <= CLS_BAD;
      logic_fn <= FN_AND;
      perm_fn  <= PERM_COPYA;
    end else begin
      valid <= en;
      if (en) begin
        op_class <= cls_d;
        logic_fn <= lfn_d;
        perm_fn  <= pfn_d;
      end
    end
  end

  a_class_known: assert property (@(posedge clk) disable iff (rst)
    valid |-> !$isunknown(op_class))
    else $error("fpu_op_decode: unknown op_class with valid high");

endmodule

/* fpu_op_pkg.sv */
/* opcode type and values, operation class and function enums,
   retire code layout and exception enable mask */
package fpu_op_pkg;

  typedef logic [7:0] op_t;

  // logic group, low two bits give the function
  localparam op_t OP_LOGIC = 8'h20;

  // half-word permutes
  localparam op_t OP_PERM_COPYA = 8'h30;
  localparam op_t OP_PERM_SWAP  = 8'h31;
  localparam op_t OP_PERM_DUP   = 8'h32;
  localparam op_t OP_PERM_MERGE = 8'h33;

  typedef enum logic [1:0] {
    CLS_LOGIC,
    CLS_PERM,
    CLS_BAD
  } op_class_e;

  // order matches the low opcode bits of the logic group
  typedef enum logic [1:0] {
    FN_AND,
    FN_OR,
    FN_XOR,
    FN_ANDN
  } logic_fn_e;

  typedef enum logic [1:0] {
    PERM_COPYA,
    PERM_SWAP,
    PERM_DUP,
    PERM_MERGE
  } perm_fn_e;

  // raw flags, then the masked exception bit above them
  localparam int NUM_FLAGS  = 3;
  localparam int RET_PAR_A  = 0;
  localparam int RET_PAR_B  = 1;
  localparam int RET_BAD_OP = 2;
  localparam int RET_EXCPT  = 3;

  typedef logic [NUM_FLAGS:0]   ret_code_t;
  typedef logic [NUM_FLAGS-1:0] csr_en_t;

endpackage

/* fpu_retire.sv */
/* result bus word with parity and retire code with masked
   exception bit */
`timescale 1ns/1ns

module fpu_retire
  import fpu_data_pkg::*;
  import fpu_op_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 valid_in,
  input  fp_data_t             data,
  input  logic [NUM_FLAGS-1:0] flags,
  input  csr_en_t              csr_en,
  output logic                 result_valid,
  output bus_word_t            result,
  output logic                 ret_valid,
  output ret_code_t            ret_code
);

  fp_data_t  data_z;
  bus_word_t word_d;
  ret_code_t code_d;

  // any raw flag kills the data, parity is rebuilt either way
  always_comb begin
    data_z                 = (|flags) ? '0 : data;
    word_d                 = '0;
    word_d[DATA_W-1:0]     = data_z;
    word_d[PAR_BIT]        = ^data_z;
    code_d                 = '0;
    code_d[NUM_FLAGS-1:0]  = flags;
    code_d[RET_EXCPT]      = |(flags & csr_en);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      ret_valid    <= 1'b0;
      result       <= '0;
      ret_code     <= '0;
    end else begin
      result_valid <= valid_in;
      ret_valid    <= valid_in;
      // idle cycles drive a zero word
      result   <= valid_in ? word_d : '0;
      ret_code <= valid_in ? code_d : '0;
    end
  end

  a_result_parity: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> (^result == 1'b0))
    else $error("fpu_retire: result word has odd parity");

endmodule

/* operand_forward.sv */
/* operand source select among direct input, bus and previous-cycle bus,
   with registered parity check */
`timescale 1ns/1ns

module operand_forward
  import fpu_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  bus_word_t direct,
  input  bus_word_t fwd_bus [NUM_BUS],
  input  bus_sel_t  fwd_sel,
  input  bus_sel_t  prev_sel,
  output fp_data_t  operand,
  output logic      par_err
);

  bus_word_t prev_bus [NUM_BUS];
  bus_word_t chosen;

  // what every bus carried one cycle ago
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_BUS; i++) begin
        prev_bus[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_BUS; i++) begin
        prev_bus[i] <= fwd_bus[i];
      end
    end
  end

  // current bus beats previous bus beats direct input
  always_comb begin
    chosen = direct;
    for (int i = 0; i < NUM_BUS; i++) begin
      if (prev_sel[i]) begin
        chosen = prev_bus[i];
      end
    end
    for (int i = 0; i < NUM_BUS; i++) begin
      if (fwd_sel[i]) begin
        chosen = fwd_bus[i];
      end
    end
  end

  // odd overall xor means a flipped bit somewhere in the word
  always_ff @(posedge clk) begin
    operand <= chosen[DATA_W-1:0];
    par_err <= ^chosen;
  end

  a_one_source: assert property (@(posedge clk) disable iff (rst)
    $onehot0({fwd_sel, prev_sel}))
    else $error("operand_forward: more than one forwarding select set");

endmodule

/* tb_fpu_lane.sv */
/* lane testbench with clock, reset, file-driven stimulus,
   reference model and per-test result checks */
`timescale 1ns/1ns

module tb_fpu_lane
  import fpu_data_pkg::*;
  import fpu_op_pkg::*;
();

  localparam int NUM_VEC    = 25;
  localparam int NUM_FIELD  = 11;
  localparam int RESET_CYC  = 3;
  localparam int PIPE_DEPTH = 3;
  localparam int MAX_CYCLES = NUM_VEC + RESET_CYC + PIPE_DEPTH + 20;

  logic      clk = 1'b0;
  logic      rst;
  logic      en;
  op_t       op;
  bus_word_t a;
  bus_word_t b;
  bus_word_t fwd_bus [NUM_BUS];
  bus_sel_t  fwd_sel_a;
  bus_sel_t  prev_sel_a;
  bus_sel_t  fwd_sel_b;
  bus_sel_t  prev_sel_b;
  csr_en_t   csr_en;
  logic      result_valid;
  bus_word_t result;
  logic      ret_valid;
  ret_code_t ret_code;

  // one word per field, NUM_FIELD fields per vector
  fp_data_t  vec_mem [0:NUM_VEC*NUM_FIELD-1];
  bus_word_t bus_cur [NUM_BUS];
  bus_word_t bus_prev [NUM_BUS];
  integer    seed = 20333;
  int        cycle_count = 0;

  // expected outputs, oldest first
  logic      exp_valid_q [$];
  bus_word_t exp_result_q [$];
  ret_code_t exp_code_q [$];
  int        exp_test_q [$];

  int cur_test = 1;
  int test_checks = 0;
  int test_errs = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int last_test = 1;

  fpu_lane dut0 (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .op           (op),
    .a            (a),
    .b            (b),
    .fwd_bus      (fwd_bus),
    .fwd_sel_a    (fwd_sel_a),
    .prev_sel_a   (prev_sel_a),
    .fwd_sel_b    (fwd_sel_b),
    .prev_sel_b   (prev_sel_b),
    .csr_en       (csr_en),
    .result_valid (result_valid),
    .result       (result),
    .ret_valid    (ret_valid),
    .ret_code     (ret_code)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("run stopped, no finish after %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic bus_word_t with_parity(fp_data_t d);
    return {^d, d};
  endfunction

  function automatic bus_word_t random_word();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return with_parity(r[DATA_W-1:0]);
  endfunction

  // same-cycle bus first, then last cycle's bus, else the direct word
  function automatic bus_word_t pick_source(bus_word_t direct, bus_sel_t fs, bus_sel_t ps);
    bus_word_t w;
    w = direct;
    for (int i = 0; i < NUM_BUS; i++) begin
      if (fs[i]) begin
        w = bus_cur[i];
      end else if (ps[i]) begin
        w = bus_prev[i];
      end
    end
    return w;
  endfunction

  function automatic logic is_listed(op_t o);
    return (o[7:2] == OP_LOGIC[7:2]) || (o == OP_PERM_COPYA) || (o == OP_PERM_SWAP) ||
           (o == OP_PERM_DUP) || (o == OP_PERM_MERGE);
  endfunction

  function automatic fp_data_t model_data(op_t o, fp_data_t x, fp_data_t y);
    fp_data_t r;
    r = '0;
    if (o[7:2] == OP_LOGIC[7:2]) begin
      case (o[1:0])
        2'd0:    r = x & y;
        2'd1:    r = x | y;
        2'd2:    r = x ^ y;
        default: r = x & ~y;
      endcase
    end else if (o == OP_PERM_COPYA) begin
      r = x;
    end else if (o == OP_PERM_SWAP) begin
      r = {x[HALF_W-1:0], x[DATA_W-1:HALF_W]};
    end else if (o == OP_PERM_DUP) begin
      r = {y[HALF_W-1:0], y[HALF_W-1:0]};
    end else if (o == OP_PERM_MERGE) begin
      r = {x[DATA_W-1:HALF_W], y[HALF_W-1:0]};
    end
    return r;
  endfunction

  task automatic finish_test();
    if (test_checks > 0) begin
      $display("test %0d %s: %0d cycles checked, %0d errors", cur_test,
               (test_errs == 0) ? "ok" : "failed", test_checks, test_errs);
      if (test_errs == 0) begin
        tests_passed++;
      end else begin
        tests_failed++;
      end
    end
    test_checks = 0;
    test_errs = 0;
  endtask

  task automatic check_outputs();
    logic      ev;
    bus_word_t er;
    ret_code_t ec;
    int        t;
    ev = exp_valid_q.pop_front();
    er = exp_result_q.pop_front();
    ec = exp_code_q.pop_front();
    t  = exp_test_q.pop_front();
    if (t != cur_test) begin
      finish_test();
      cur_test = t;
    end
    test_checks++;
    assert (result_valid === ev) else begin
      if (ev) $display("test %0d: result_valid missing at cycle %0d", t, cycle_count);
      else $display("test %0d: result_valid high with no result due at cycle %0d", t,
                    cycle_count);
      test_errs++;
    end
    assert (ret_valid === ev) else begin
      if (ev) $display("test %0d: ret_valid missing at cycle %0d", t, cycle_count);
      else $display("test %0d: ret_valid high with no retire due at cycle %0d", t,
                    cycle_count);
      test_errs++;
    end
    assert (result === er) else begin
      $display("** Error result: expected %h, got %h", er, result);
      test_errs++;
    end
    assert (ret_code === ec) else begin
      $display("** Error ret_code: expected %h, got %h", ec, ret_code);
      test_errs++;
    end
  endtask

  task automatic push_expected(int t, logic v, bus_word_t r, ret_code_t c);
    exp_valid_q.push_back(v);
    exp_result_q.push_back(r);
    exp_code_q.push_back(c);
    exp_test_q.push_back(t);
  endtask

  task automatic drive_vector(int j);
    int        base;
    bus_word_t wa;
    bus_word_t wb;
    logic [2:0] flags;
    fp_data_t  d;
    ret_code_t c;
    base = j * NUM_FIELD;
    for (int i = 0; i < NUM_BUS; i++) begin
      bus_prev[i] = bus_cur[i];
      bus_cur[i]  = random_word();
      fwd_bus[i]  = bus_cur[i];
    end
    if (j >= NUM_VEC) begin
      en = 1'b0;
      push_expected(last_test, 1'b0, '0, '0);
    end else begin
      last_test  = vec_mem[base][7:0];
      en         = vec_mem[base+1][0];
      op         = vec_mem[base+2][7:0];
      fwd_sel_a  = vec_mem[base+3][NUM_BUS-1:0];
      prev_sel_a = vec_mem[base+4][NUM_BUS-1:0];
      fwd_sel_b  = vec_mem[base+5][NUM_BUS-1:0];
      prev_sel_b = vec_mem[base+6][NUM_BUS-1:0];
      a          = with_parity(vec_mem[base+7]);
      b          = with_parity(vec_mem[base+8]);
      csr_en     = vec_mem[base+9][2:0];
      a[PAR_BIT] = a[PAR_BIT] ^ vec_mem[base+10][0];
      b[PAR_BIT] = b[PAR_BIT] ^ vec_mem[base+10][1];
      if (en) begin
        wa = pick_source(a, fwd_sel_a, prev_sel_a);
        wb = pick_source(b, fwd_sel_b, prev_sel_b);
        flags[RET_PAR_A]  = ^wa;
        flags[RET_PAR_B]  = ^wb;
        flags[RET_BAD_OP] = !is_listed(op);
        d = (|flags) ? '0 : model_data(op, wa[DATA_W-1:0], wb[DATA_W-1:0]);
        c = '0;
        c[2:0] = flags;
        c[RET_EXCPT] = |(flags & csr_en);
        push_expected(last_test, 1'b1, with_parity(d), c);
      end else begin
        push_expected(last_test, 1'b0, '0, '0);
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    en = 1'b0;
    op = '0;
    a = '0;
    b = '0;
    fwd_sel_a = '0;
    prev_sel_a = '0;
    fwd_sel_b = '0;
    prev_sel_b = '0;
    csr_en = 3'b111;
    for (int i = 0; i < NUM_BUS; i++) begin
      bus_cur[i] = '0;
      bus_prev[i] = '0;
      fwd_bus[i] = '0;
    end
    $readmemh("fpu_lane_input.hex", vec_mem);
    assert (!$isunknown(vec_mem[NUM_VEC*NUM_FIELD-1])) else begin
      $display("stimulus file fpu_lane_input.hex did not load all %0d vectors", NUM_VEC);
      tests_failed++;
    end
    // idle outputs expected while the pipe fills after reset
    for (int i = 0; i < PIPE_DEPTH; i++) begin
      push_expected(1, 1'b0, '0, '0);
    end
    repeat (RESET_CYC) @(posedge clk);
    #1 rst = 1'b0;
    for (int j = 0; j < NUM_VEC + PIPE_DEPTH; j++) begin
      check_outputs();
      drive_vector(j);
      @(posedge clk);
      #1;
    end
    finish_test();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
